/* common/boot_pkg.sv */
// boot stream format, shared by the parser and the CRC checker
// a command class comes from the top bits of the command byte only
// CRC is the reflected CRC-32, LSB first, with no final inversion
// sink codes other than SINK_CODE and SINK_DATA are valid but write nothing
package boot_pkg;

  // ====================
  // stream constants
  localparam logic [2:0]  SINK_CODE = 3'd0;            // sink field, code RAM
  localparam logic [2:0]  SINK_DATA = 3'd1;            // sink field, data RAM
  localparam int          SIG_BYTES = 4;               // signature length in bytes
  localparam logic [31:0] CRC_INIT  = 32'hFFFF_FFFF;   // start value
  localparam logic [31:0] CRC_POLY  = 32'hEDB8_8320;   // 04C11DB7 bit-reversed

  typedef enum logic [2:0] {
    CMD_DATA,                                          // 0x/01 data run
    CMD_SET,                                           // 110 set dest or count
    CMD_RATE,                                          // 10 sclk rate, ignored
    CMD_SIGN,                                          // 1110 signature follows
    CMD_END                                            // 1111 plain end
  } cmd_class_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,                                            // expecting a command byte
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_LEN_HI,
    ST_LEN_LO,
    ST_DATA,                                           // packing words
    ST_SIG                                             // signature bytes
  } parse_state_t;

  function automatic cmd_class_t cmd_class(input logic [7:0] b);
    cmd_class_t c;
    casez (b)
      8'b0???_????: c = CMD_DATA;
      8'b10??_????: c = CMD_RATE;
      8'b110?_????: c = CMD_SET;                       // bit 1 picks dest/count
      8'b1110_????: c = CMD_SIGN;
      default:      c = CMD_END;
    endcase
    return c;
  endfunction

endpackage

/* common/mem_pkg.sv */
// widths of the code and data RAM write ports
// code words are 16 bits, data words 24 bits
// the destination register is wider than both address buses,
// upper bits are dropped at the ports
package mem_pkg;

  // ====================
  // widths
  localparam int CODE_AW = 12;                         // 4k code words
  localparam int DATA_AW = 11;                         // 2k data words
  localparam int CODE_W  = 16;
  localparam int DATA_W  = 24;
  localparam int DEST_W  = 16;                         // dest and count regs

  // ====================
  // types
  typedef logic [CODE_AW-1:0] code_addr_t;
  typedef logic [DATA_AW-1:0] data_addr_t;
  typedef logic [CODE_W-1:0]  code_word_t;
  typedef logic [DATA_W-1:0]  data_word_t;
  typedef logic [DEST_W-1:0]  dest_t;

endpackage

/* common/boot_regs_if.sv */
// link between the stream parser and the destination/count registers
// load strobes are one-cycle pulses, ld_byte is valid while a strobe is high
// cnt_zero already accounts for a word_wr in the same cycle
`timescale 1ns/1ps

interface boot_regs_if;
  import mem_pkg::*;

  logic       ld_dest_hi;                              // load dest[15:8]
  logic       ld_dest_lo;                              // load dest[7:0]
  logic       ld_cnt_hi;                               // load count[15:8]
  logic       ld_cnt_lo;                               // load count[7:0]
  logic [7:0] ld_byte;                                 // byte for the load
  logic       word_wr;                                 // a word went out
  dest_t      dest;                                    // current destination
  logic       cnt_zero;                                // last word of the run

  modport parser (
    output ld_dest_hi, ld_dest_lo, ld_cnt_hi, ld_cnt_lo, ld_byte, word_wr,
    input  dest, cnt_zero
  );

  modport regs (
    input  ld_dest_hi, ld_dest_lo, ld_cnt_hi, ld_cnt_lo, ld_byte, word_wr,
    output dest, cnt_zero
  );

endinterface

/* boot_loader/boot_regs.sv */
// destination address and remaining-word count of the boot run
// both clear on i_start, a new run starts at address 0 with count 0
// count 0 means one more word, the count stops at zero
// cnt_zero looks ahead past a decrement of the same cycle
`timescale 1ns/1ps

module boot_regs (
  input  logic      clk,
  input  logic      arstn,
  input  logic      i_start,
  boot_regs_if.regs regs
);
  import mem_pkg::*;

  dest_t dest;                                         // write address
  dest_t count;                                        // words left - 1

  // ====================
  // registers
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      dest  <= '0;
      count <= '0;
    end else if (i_start) begin
      dest  <= '0;
      count <= '0;
    end else begin
      if (regs.ld_dest_hi) dest[DEST_W-1:8] <= regs.ld_byte;
      if (regs.ld_dest_lo) dest[7:0]        <= regs.ld_byte;
      if (regs.ld_cnt_hi)  count[DEST_W-1:8] <= regs.ld_byte;
      if (regs.ld_cnt_lo)  count[7:0]        <= regs.ld_byte;
      if (regs.word_wr) begin
        dest <= dest + 1'b1;                           // bump after the write
        if (count != '0) count <= count - 1'b1;
      end
    end
  end

  assign regs.dest     = dest;
  // a pending word_wr has not been counted yet
  assign regs.cnt_zero = regs.word_wr ? (count <= dest_t'(1)) : (count == '0);

  a_no_ld_on_wr: assert property (@(posedge clk) disable iff (!arstn)
    (regs.ld_dest_hi || regs.ld_dest_lo || regs.ld_cnt_hi || regs.ld_cnt_lo)
    |-> !regs.word_wr);

endmodule

/* boot_loader/boot_parser.sv */
// boot stream interpreter, takes one byte per cycle while busy
// write strobes come one cycle after the last byte of a word
// the write address is the destination before its increment
// words pack big-endian, wider packs keep only the low bits
// i_start restarts the run from any state
`timescale 1ns/1ps

module boot_parser (
  input  logic                clk,
  input  logic                arstn,
  input  logic                i_start,               // arm a new run
  input  logic [7:0]          i_byte,
  input  logic                i_valid,
  output logic                o_ready,
  output logic                o_busy,
  output logic                o_done,
  output logic                o_code_we,
  output mem_pkg::code_addr_t o_code_addr,
  output mem_pkg::code_word_t o_code_data,
  output logic                o_data_we,
  output mem_pkg::data_addr_t o_data_addr,
  output mem_pkg::data_word_t o_data_data,
  output logic                o_crc_upd,             // byte is crc payload
  output logic                o_sig_byte,            // byte is signature
  boot_regs_if.parser         regs
);
  import boot_pkg::*;
  import mem_pkg::*;

  parse_state_t                 state;
  cmd_class_t                   cls;
  logic [2:0]                   sink;                  // selected sink
  logic [1:0]                   bpw;                   // bytes per word - 1
  logic [1:0]                   bcnt;                  // bytes left in word - 1
  logic [$clog2(SIG_BYTES)-1:0] sig_cnt;
  data_word_t                   pack;                  // word being packed
  data_word_t                   pack_nxt;
  data_word_t                   wr_word;               // word on the RAM ports
  logic                         xfer;
  logic                         word_end;

  assign o_busy   = (state != ST_IDLE);
  assign o_ready  = o_busy;
  assign xfer     = i_valid & o_ready;                 // handshake
  assign cls      = cmd_class(i_byte);
  assign word_end = xfer && (state == ST_DATA) && (bcnt == 2'd0);
  assign pack_nxt = {pack[DATA_W-9:0], i_byte};        // shift in, big-endian

  // everything before the signature is covered by the crc
  assign o_crc_upd  = xfer && (state != ST_SIG);
  assign o_sig_byte = xfer && (state == ST_SIG);

  assign o_code_addr = regs.dest[CODE_AW-1:0];
  assign o_data_addr = regs.dest[DATA_AW-1:0];
  assign o_code_data = wr_word[CODE_W-1:0];
  assign o_data_data = wr_word;

  // ====================
  // control FSM
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state           <= ST_IDLE;
      sink            <= '0;
      bpw             <= '0;
      bcnt            <= '0;
      sig_cnt         <= '0;
      o_done          <= 1'b0;
      o_code_we       <= 1'b0;
      o_data_we       <= 1'b0;
      regs.ld_dest_hi <= 1'b0;
      regs.ld_dest_lo <= 1'b0;
      regs.ld_cnt_hi  <= 1'b0;
      regs.ld_cnt_lo  <= 1'b0;
      regs.word_wr    <= 1'b0;
    end else begin
      regs.ld_dest_hi <= 1'b0;                         // strobes
      regs.ld_dest_lo <= 1'b0;
      regs.ld_cnt_hi  <= 1'b0;
      regs.ld_cnt_lo  <= 1'b0;
      regs.word_wr    <= word_end;                     // dest++ and count--
      o_code_we       <= word_end && (sink == SINK_CODE);
      o_data_we       <= word_end && (sink == SINK_DATA);
      if (i_start) begin
        state   <= ST_CMD;
        sig_cnt <= '0;
        o_done  <= 1'b0;
      end else if (xfer) begin
        case (state)
          ST_CMD: begin
            case (cls)
              CMD_DATA: begin
                state <= ST_DATA;
                sink  <= i_byte[4:2];
                bpw   <= i_byte[1:0];
                bcnt  <= i_byte[1:0];
              end
              CMD_SET:  state <= i_byte[1] ? ST_LEN_HI : ST_ADDR_HI;
              CMD_SIGN: state <= ST_SIG;
              CMD_END: begin
                state  <= ST_IDLE;                     // unsigned finish
                o_done <= 1'b1;
              end
              default: state <= ST_CMD;                // rate byte, no effect
            endcase
          end
          ST_ADDR_HI: begin
            regs.ld_dest_hi <= 1'b1;
            state           <= ST_ADDR_LO;
          end
          ST_ADDR_LO: begin
            regs.ld_dest_lo <= 1'b1;
            state           <= ST_CMD;
          end
          ST_LEN_HI: begin
            regs.ld_cnt_hi <= 1'b1;
            state          <= ST_LEN_LO;
          end
          ST_LEN_LO: begin
            regs.ld_cnt_lo <= 1'b1;
            state          <= ST_CMD;
          end
          ST_DATA: begin
            if (bcnt != 2'd0) begin
              bcnt <= bcnt - 2'd1;
            end else begin
              bcnt <= bpw;                             // next word
              if (regs.cnt_zero) state <= ST_CMD;      // run complete
            end
          end
          ST_SIG: begin
            if (sig_cnt == ($clog2(SIG_BYTES))'(SIG_BYTES - 1)) begin
              state  <= ST_IDLE;
              o_done <= 1'b1;
            end else begin
              sig_cnt <= sig_cnt + 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // ====================
  // payload path
  always_ff @(posedge clk) begin
    if (xfer) regs.ld_byte <= i_byte;                  // used only with a strobe
    if (xfer && (state == ST_CMD)) begin
      pack <= '0;                                      // clean start per run
    end else if (word_end) begin
      wr_word <= pack_nxt;
      pack    <= '0;                                   // cleared after each word
    end else if (xfer && (state == ST_DATA)) begin
      pack <= pack_nxt;
    end
  end

  a_one_we: assert property (@(posedge clk) disable iff (!arstn)
    !(o_code_we && o_data_we));
  a_done_idle: assert property (@(posedge clk) disable iff (!arstn)
    o_done |-> !o_busy);

endmodule

/* source/crc32_check.sv */
// running CRC-32 over the payload bytes of a boot run
// reflected polynomial, init all ones, no final inversion
// signature arrives most significant byte first
// o_sig_ok is 0 until all signature bytes are seen and matched
`timescale 1ns/1ps

module crc32_check (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_start,
  input  logic [7:0] i_byte,
  input  logic       i_upd,                            // fold byte into crc
  input  logic       i_sig,                            // compare signature byte
  output logic       o_sig_ok
);
  import boot_pkg::*;

  localparam int SCW = $clog2(SIG_BYTES);

  logic [31:0]    crc;
  logic [SCW-1:0] sig_cnt;                             // signature byte index
  logic           all_ok;                              // matches so far
  logic [7:0]     crc_sel;
  logic           byte_ok;

  // one byte, bit by bit, LSB first
  function automatic logic [31:0] crc_fold(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ b[i];
      r  = r >> 1;
      if (fb) r = r ^ CRC_POLY;
    end
    return r;
  endfunction

  assign crc_sel = crc[8*(SIG_BYTES-1-sig_cnt) +: 8]; // msb first
  assign byte_ok = (crc_sel == i_byte);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      crc      <= CRC_INIT;
      sig_cnt  <= '0;
      all_ok   <= 1'b0;
      o_sig_ok <= 1'b0;
    end else if (i_start) begin
      crc      <= CRC_INIT;
      sig_cnt  <= '0;
      all_ok   <= 1'b1;
      o_sig_ok <= 1'b0;
    end else if (i_upd) begin
      crc <= crc_fold(crc, i_byte);
    end else if (i_sig) begin
      all_ok <= all_ok & byte_ok;
      if (sig_cnt == SCW'(SIG_BYTES - 1)) begin
        o_sig_ok <= all_ok & byte_ok;                  // last byte decides
        sig_cnt  <= '0;
      end else begin
        sig_cnt <= sig_cnt + 1'b1;
      end
    end
  end

  a_upd_xor_sig: assert property (@(posedge clk) disable iff (!arstn)
    !(i_upd && i_sig));

endmodule

/* source/boot_loader_top.sv */
// boot loader top, plaintext byte stream in, two RAM write ports out
// o_ready follows o_busy, a byte moves when i_valid and o_ready are high
// RAM ports accept a write every cycle, there is no back-pressure
// o_done and o_sig_ok hold until the next i_start
`timescale 1ns/1ps

module boot_loader_top (
  input  logic                clk,
  input  logic                arstn,
  input  logic                i_start,
  input  logic [7:0]          i_byte,
  input  logic                i_valid,
  output logic                o_ready,
  output logic                o_code_we,
  output mem_pkg::code_addr_t o_code_addr,
  output mem_pkg::code_word_t o_code_data,
  output logic                o_data_we,
  output mem_pkg::data_addr_t o_data_addr,
  output mem_pkg::data_word_t o_data_data,
  output logic                o_busy,
  output logic                o_done,
  output logic                o_sig_ok
);

  logic crc_upd;                                       // payload byte strobe
  logic sig_byte;                                      // signature byte strobe

  boot_regs_if u_regs_if ();

  boot_parser u_parser (
    .clk         (clk),
    .arstn       (arstn),
    .i_start     (i_start),
    .i_byte      (i_byte),
    .i_valid     (i_valid),
    .o_ready     (o_ready),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_code_we   (o_code_we),
    .o_code_addr (o_code_addr),
    .o_code_data (o_code_data),
    .o_data_we   (o_data_we),
    .o_data_addr (o_data_addr),
    .o_data_data (o_data_data),
    .o_crc_upd   (crc_upd),
    .o_sig_byte  (sig_byte),
    .regs        (u_regs_if.parser)
  );

  boot_regs u_regs (
    .clk     (clk),
    .arstn   (arstn),
    .i_start (i_start),
    .regs    (u_regs_if.regs)
  );

  crc32_check u_crc (
    .clk      (clk),
    .arstn    (arstn),
    .i_start  (i_start),
    .i_byte   (i_byte),
    .i_upd    (crc_upd),
    .i_sig    (sig_byte),
    .o_sig_ok (o_sig_ok)
  );

endmodule

/* tb/boot_loader_tb.sv */
// boot loader testbench streaming the run table twice
// pass 0 streams back to back and pass 1 adds LFSR-driven i_valid gaps
// signature bytes are built here from the payload bytes of each run
// expected writes are listed in stream order over all runs
`timescale 1ns/1ps

module boot_loader_tb;
  import boot_pkg::*;
  import mem_pkg::*;

  // ====================
  // tables
  localparam int N_PAY       = 45;
  localparam int N_RUN       = 3;
  localparam int N_WR        = 7;
  localparam int N_PASS      = 2;
  localparam int RST_CYCLES  = 4;
  localparam int STREAM_LEN  = N_PASS * (N_PAY + 2 * SIG_BYTES);  // two signed runs
  localparam int CYCLE_LIMIT = 4 * STREAM_LEN + RST_CYCLES;

  localparam logic [7:0] PAYLOAD [N_PAY] = '{
    8'hC0, 8'h01, 8'h00, 8'hC2, 8'h00, 8'h02,          // dest 0x0100 and 3 words
    8'h01, 8'h12, 8'h34, 8'h56, 8'h78, 8'h9A, 8'hBC,   // code run with 2 bytes per word
    8'hC2, 8'h00, 8'h01, 8'h06,                        // data run with 3 bytes per word
    8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66,
    8'h85, 8'hC2, 8'h00, 8'h01, 8'h15,                 // rate byte and a sink 5 run
    8'hAA, 8'hBB, 8'hCC, 8'hDD, 8'hE0,                 // signature follows
    8'hC0, 8'h00, 8'h10, 8'h00, 8'h7E, 8'hE0,          // run 1 writes a single byte word
    8'h03, 8'h01, 8'h02, 8'h03, 8'h04, 8'hF0           // run 2 packs 4 bytes and ends plain
  };
  localparam int   RUN_FIRST  [N_RUN] = '{0, 33, 39};
  localparam int   RUN_LEN    [N_RUN] = '{33, 6, 6};
  localparam int   RUN_KIND   [N_RUN] = '{1, 2, 0};     // 0 unsigned, 1 signed, 2 bad sig
  localparam logic RUN_SIG_OK [N_RUN] = '{1'b1, 1'b0, 1'b0};

  localparam logic       EXP_SINK [N_WR] = '{0, 0, 0, 1, 1, 0, 0};  // 1 = data port
  localparam dest_t      EXP_ADDR [N_WR] = '{16'h0100, 16'h0101, 16'h0102, 16'h0103,
                                             16'h0104, 16'h0010, 16'h0000};
  localparam data_word_t EXP_WORD [N_WR] = '{24'h001234, 24'h005678, 24'h009ABC,
                                             24'h112233, 24'h445566, 24'h00007E,
                                             24'h000304};  // low 16 bits of 0x01020304

  logic        clk = 1'b0;
  logic        arstn;
  logic        i_start;
  logic [7:0]  i_byte;
  logic        i_valid;
  logic        o_ready;
  logic        o_code_we;
  code_addr_t  o_code_addr;
  code_word_t  o_code_data;
  logic        o_data_we;
  data_addr_t  o_data_addr;
  data_word_t  o_data_data;
  logic        o_busy;
  logic        o_done;
  logic        o_sig_ok;
  logic [15:0] lfsr    = 16'd3605;                     // gap source
  int          cycles  = 0;
  int          wr_idx  = 0;                            // writes seen so far
  int          pass_no = 0;

  boot_loader_top DUT (.*);

  always #20 clk = ~clk;                               // 40 ns period

  // ====================
  // helpers
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];                // x^16+x^14+x^13+x^11+1
    return {s[14:0], fb};
  endfunction

  task automatic next_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  // reflected CRC-32 taking each byte LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c;
    for (int k = 0; k < 8; k++) begin
      if (r[0] ^ b[k]) r = (r >> 1) ^ CRC_POLY;
      else r = r >> 1;
    end
    return r;
  endfunction

  task automatic stop_fail(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_fail($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_code(input code_addr_t got_a, input code_word_t got_w,
                            input code_addr_t exp_a, input code_word_t exp_w);
    if (got_a !== exp_a || got_w !== exp_w) begin
      stop_fail($sformatf("Fail at %0t ns: code write %h at %h, expected %h at %h",
                          $time, got_w, got_a, exp_w, exp_a));
    end
  endtask

  task automatic check_data(input data_addr_t got_a, input data_word_t got_w,
                            input data_addr_t exp_a, input data_word_t exp_w);
    if (got_a !== exp_a || got_w !== exp_w) begin
      stop_fail($sformatf("Fail at %0t ns: data write %h at %h, expected %h at %h",
                          $time, got_w, got_a, exp_w, exp_a));
    end
  endtask

  // returns one half cycle before the edge that takes the byte
  task automatic send_byte(input logic [7:0] b, input bit gaps);
    logic       g0;
    logic       g1;
    logic [1:0] gap;
    gap = 2'd0;
    if (gaps) begin
      next_bit(g0);
      next_bit(g1);
      gap = {g1, g0};                                  // 0..3 idle cycles
    end
    repeat (gap) begin
      @(posedge clk);
      i_valid <= 1'b0;
    end
    @(posedge clk);
    i_byte  <= b;
    i_valid <= 1'b1;
    @(negedge clk);
    while (!o_ready) @(negedge clk);
  endtask

  // ====================
  // write monitor and timeout
  always @(negedge clk) begin
    if (arstn && (o_code_we || o_data_we)) begin
      if (wr_idx >= N_WR * (pass_no + 1)) begin
        stop_fail("a RAM write occurred that the table does not expect");
      end else begin
        check_flag(o_data_we, EXP_SINK[wr_idx % N_WR], "data port select");
        if (o_code_we) begin
          check_code(o_code_addr, o_code_data, code_addr_t'(EXP_ADDR[wr_idx % N_WR]),
                     code_word_t'(EXP_WORD[wr_idx % N_WR]));
        end else begin
          check_data(o_data_addr, o_data_data, data_addr_t'(EXP_ADDR[wr_idx % N_WR]),
                     EXP_WORD[wr_idx % N_WR]);
        end
        wr_idx = wr_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_fail($sformatf("timeout, the test did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // ====================
  // stimulus
  initial begin
    logic [31:0] crc;
    logic [7:0]  sb;
    bit          gaps;
    arstn   = 1'b0;
    i_start = 1'b0;
    i_byte  = 8'h00;
    i_valid = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arstn <= 1'b1;
    @(negedge clk);
    check_flag(o_busy, 1'b0, "o_busy after reset");
    check_flag(o_ready, 1'b0, "o_ready after reset");
    check_flag(o_done, 1'b0, "o_done after reset");
    check_flag(o_sig_ok, 1'b0, "o_sig_ok after reset");
    check_flag(o_code_we, 1'b0, "o_code_we after reset");
    check_flag(o_data_we, 1'b0, "o_data_we after reset");
    for (int p = 0; p < N_PASS; p++) begin
      pass_no = p;
      gaps    = (p == 1);
      for (int r = 0; r < N_RUN; r++) begin
        @(posedge clk);
        i_start <= 1'b1;                               // one cycle pulse
        @(posedge clk);
        i_start <= 1'b0;
        @(negedge clk);
        check_flag(o_busy, 1'b1, "o_busy after i_start");
        check_flag(o_done, 1'b0, "o_done after i_start");
        crc = CRC_INIT;
        for (int i = 0; i < RUN_LEN[r]; i++) begin
          sb  = PAYLOAD[RUN_FIRST[r] + i];
          crc = crc_byte(crc, sb);                     // includes the 0xE0 byte
          send_byte(sb, gaps);
          check_flag(o_done, 1'b0, "o_done before the end of the run");
        end
        if (RUN_KIND[r] != 0) begin
          for (int k = SIG_BYTES - 1; k >= 0; k--) begin
            sb = crc[8*k +: 8];                        // msb first
            if (RUN_KIND[r] == 2 && k == 2) sb = sb ^ 8'h10;
            send_byte(sb, gaps);
            check_flag(o_done, 1'b0, "o_done before the last signature byte");
          end
        end
        @(posedge clk);
        i_valid <= 1'b0;                               // terminating byte moves here
        @(negedge clk);
        check_flag(o_done, 1'b1, "o_done after the terminating byte");
        check_flag(o_sig_ok, RUN_SIG_OK[r], $sformatf("o_sig_ok of run %0d", r));
        check_flag(o_busy, 1'b0, "o_busy with o_done");
        // bytes offered after the end are refused
        @(posedge clk);
        i_byte  <= 8'h01;
        i_valid <= 1'b1;
        repeat (3) begin
          @(negedge clk);
          check_flag(o_ready, 1'b0, "o_ready after the end");
          check_flag(o_done, 1'b1, "o_done held until i_start");
        end
        @(posedge clk);
        i_valid <= 1'b0;
      end
    end
    if (wr_idx == N_WR * N_PASS) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_fail($sformatf("%0d of the %0d expected RAM writes never happened",
                          N_WR * N_PASS - wr_idx, N_WR * N_PASS));
    end
  end

endmodule

/* files.f */
common/boot_pkg.sv
common/mem_pkg.sv
common/boot_regs_if.sv
boot_loader/boot_regs.sv
boot_loader/boot_parser.sv
source/crc32_check.sv
source/boot_loader_top.sv
tb/boot_loader_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the boot loader testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module boot_loader_tb \
  -f files.f -o boot_loader_sim
out=$(./obj_dir/boot_loader_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
exit 1
